//--- width_reduce.f
design/width_reduce_pkg.sv
design/ingress_gate.sv
design/stream_fifo.sv
design/width_reducer.sv
design/width_reduce_top.sv
bench/width_reduce_assert.sv
bench/width_reduce_tb.sv

//--- bench/width_reduce_tb.sv
`timescale 1ns/100ps

module width_reduce_tb;

  import width_reduce_pkg::*;

  localparam int DIN_WIDTH = DEFAULT_DIN_WIDTH;
  localparam int DOUT_WIDTH = DEFAULT_DOUT_WIDTH;
  localparam int LANES = DIN_WIDTH / DOUT_WIDTH;
  localparam int WAIT_LIMIT = 400;

  logic CLK;
  logic RESETN;
  logic [DIN_WIDTH-1:0] din;
  logic din_valid;
  logic ready;
  logic [DOUT_WIDTH-1:0] dout;
  logic dout_valid;
  logic [DROP_COUNT_WIDTH-1:0] drop_count;

  logic [31:0] lcg_state;
  int timeout_count;
  int assert_fails;

  width_reduce_top #(
    .DIN_WIDTH          (DIN_WIDTH),
    .DOUT_WIDTH         (DOUT_WIDTH),
    .FIFO_DEPTH         (DEFAULT_FIFO_DEPTH),
    .ALMOST_FULL_MARGIN (DEFAULT_ALMOST_FULL_MARGIN)
  ) u_width_reduce_top (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .din        (din),
    .din_valid  (din_valid),
    .ready      (ready),
    .dout       (dout),
    .dout_valid (dout_valid),
    .drop_count (drop_count)
  );

  // checker sees the internal FIFO flags and level
  bind width_reduce_top width_reduce_assert #(
    .DIN_WIDTH  (DIN_WIDTH),
    .DOUT_WIDTH (DOUT_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_width_reduce_assert (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .din         (din),
    .din_valid   (din_valid),
    .full        (full),
    .almost_full (almost_full),
    .level       (level),
    .ready       (ready),
    .dout        (dout),
    .dout_valid  (dout_valid),
    .drop_count  (drop_count)
  );

  always #4 CLK = ~CLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic random_word(output logic [DIN_WIDTH-1:0] word);
    for (int i = 0; i < DIN_WIDTH / 32; i++) begin
      lcg_state = lcg_next(lcg_state);
      word[i*32 +: 32] = lcg_state;
    end
  endtask

  // back-to-back words, one per cycle, ready not consulted
  task automatic offer_words(input int count);
    logic [DIN_WIDTH-1:0] word;
    for (int n = 0; n < count; n++) begin
      random_word(word);
      din = word;
      din_valid = 1'b1;
      @(negedge CLK);
    end
    din_valid = 1'b0;
  endtask

  task automatic wait_for_ready(input string phase);
    int cycles;
    cycles = 0;
    while (!ready && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!ready) begin
      $display("ready stayed low for %0d cycles during %s", WAIT_LIMIT, phase);
      timeout_count++;
    end
  endtask

  task automatic wait_for_output(input string phase);
    int cycles;
    cycles = 0;
    while (!dout_valid && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!dout_valid) begin
      $display("no output lane appeared within %0d cycles during %s", WAIT_LIMIT, phase);
      timeout_count++;
    end
  endtask

  // two quiet word periods mean nothing is left in flight
  task automatic wait_for_drain(input string phase);
    int cycles;
    int quiet;
    cycles = 0;
    quiet = 0;
    while (quiet < 2 * LANES && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
      quiet = dout_valid ? 0 : quiet + 1;
    end
    if (quiet < 2 * LANES) begin
      $display("output did not go idle within %0d cycles during %s", WAIT_LIMIT, phase);
      timeout_count++;
    end
  endtask

  initial begin
    CLK = 1'b0;
    RESETN = 1'b0;
    din = '0;
    din_valid = 1'b0;
    lcg_state = 32'hc9465585;
    timeout_count = 0;
    repeat (8) @(negedge CLK);
    RESETN = 1'b1;

    // single words into an idle pipeline
    for (int n = 0; n < 4; n++) begin
      wait_for_ready("single words");
      offer_words(1);
      wait_for_output("single words");
      wait_for_drain("single words");
    end

    // one word per lane period keeps the output busy
    for (int n = 0; n < 12; n++) begin
      offer_words(1);
      repeat (LANES - 1) @(negedge CLK);
    end
    wait_for_drain("bursts");

    // flood well past the FIFO depth, forces drops
    wait_for_ready("flood");
    offer_words(24);

    // drain
    wait_for_ready("drain");
    wait_for_drain("drain");
    repeat (4) @(negedge CLK);

    assert_fails = u_width_reduce_top.u_width_reduce_assert.fail_count;
    $display("assertion failures: %0d, timeouts: %0d, words dropped: %0d",
             assert_fails, timeout_count, drop_count);
    if (assert_fails == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- bench/width_reduce_assert.sv
`timescale 1ns/100ps

module width_reduce_assert #(
  parameter int DIN_WIDTH          = width_reduce_pkg::DEFAULT_DIN_WIDTH,
  parameter int DOUT_WIDTH         = width_reduce_pkg::DEFAULT_DOUT_WIDTH,
  parameter int FIFO_DEPTH         = width_reduce_pkg::DEFAULT_FIFO_DEPTH
) (
  input logic                                          CLK,
  input logic                                          RESETN,
  input logic [DIN_WIDTH-1:0]                          din,
  input logic                                          din_valid,
  input logic                                          full,
  input logic                                          almost_full,
  input logic [width_reduce_pkg::ceil_log2(FIFO_DEPTH+1)-1:0] level,
  input logic                                          ready,
  input logic [DOUT_WIDTH-1:0]                         dout,
  input logic                                          dout_valid,
  input logic [width_reduce_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);

  import width_reduce_pkg::*;

  localparam int LANES = DIN_WIDTH / DOUT_WIDTH;

  logic [DOUT_WIDTH-1:0] lane_q [$];
  logic [DOUT_WIDTH-1:0] exp_lane;
  logic [DROP_COUNT_WIDTH-1:0] drop_model;
  int lanes_pending;
  // lanes from words accepted at least two edges back
  int older_lanes;
  int fail_count = 0;

  // lanes of accepted words, oldest first
  always @(posedge CLK) begin
    if (!RESETN) begin
      lane_q.delete();
      exp_lane <= '1;
      lanes_pending <= 0;
      older_lanes <= 0;
      drop_model <= '0;
    end else begin
      if (dout_valid && lane_q.size() > 0) begin
        void'(lane_q.pop_front());
      end
      older_lanes <= lane_q.size();
      if (din_valid && !full) begin
        for (int i = 0; i < LANES; i++) begin
          lane_q.push_back(din[i*DOUT_WIDTH +: DOUT_WIDTH]);
        end
      end
      if (din_valid && full && drop_model != '1) begin
        drop_model <= drop_model + 1'b1;
      end
      lanes_pending <= lane_q.size();
      exp_lane <= (lane_q.size() > 0) ? lane_q[0] : '1;
    end
  end

  a_lane_data: assert property (@(posedge CLK) disable iff (!RESETN)
    dout_valid |-> (lanes_pending > 0 && dout == exp_lane))
    else begin
      fail_count++;
      $error("FAIL lane_data expected %h actual %h", $sampled(exp_lane), $sampled(dout));
    end

  // empty idle pipeline, lane 0 two edges after the write edge
  a_first_lane: assert property (@(posedge CLK) disable iff (!RESETN)
    (din_valid && !full && lanes_pending == 0) |-> ##2 !dout_valid ##1 dout_valid)
    else begin
      fail_count++;
      $error("FAIL first_lane expected dout_valid at third edge actual %b",
             $sampled(dout_valid));
    end

  a_no_gap: assert property (@(posedge CLK) disable iff (!RESETN)
    (dout_valid && older_lanes > 1) |=> dout_valid)
    else begin
      fail_count++;
      $error("FAIL no_gap expected dout_valid 1 actual %b", $sampled(dout_valid));
    end

  a_drop_count: assert property (@(posedge CLK) disable iff (!RESETN)
    drop_count == drop_model)
    else begin
      fail_count++;
      $error("FAIL drop_count expected %0d actual %0d", $sampled(drop_model),
             $sampled(drop_count));
    end

  a_ready_low: assert property (@(posedge CLK) disable iff (!RESETN)
    (full || almost_full) |=> !ready)
    else begin
      fail_count++;
      $error("FAIL ready_low expected 0 actual %b", $sampled(ready));
    end

  a_ready_high: assert property (@(posedge CLK) disable iff (!RESETN)
    !(full || almost_full) |=> ready)
    else begin
      fail_count++;
      $error("FAIL ready_high expected 1 actual %b", $sampled(ready));
    end

  // buffered words are all unsent, and at most one word and one lane wait downstream
  a_fifo_level: assert property (@(posedge CLK) disable iff (!RESETN)
    (level * LANES <= lanes_pending) &&
    (lanes_pending <= level * LANES + LANES + 1))
    else begin
      fail_count++;
      $error("FIFO level %0d does not fit %0d unsent lanes", $sampled(level),
             $sampled(lanes_pending));
    end

  a_reset_state: assert property (@(posedge CLK)
    $rose(RESETN) |-> (!dout_valid && !ready && dout == '1 && drop_count == '0))
    else begin
      fail_count++;
      $error("outputs were not at their reset values when reset was released");
    end

endmodule

//--- design/width_reduce_top.sv
`timescale 1ns/100ps

module width_reduce_top #(
  parameter int DIN_WIDTH          = width_reduce_pkg::DEFAULT_DIN_WIDTH,
  parameter int DOUT_WIDTH         = width_reduce_pkg::DEFAULT_DOUT_WIDTH,
  parameter int FIFO_DEPTH         = width_reduce_pkg::DEFAULT_FIFO_DEPTH,
  parameter int ALMOST_FULL_MARGIN = width_reduce_pkg::DEFAULT_ALMOST_FULL_MARGIN
) (
  input  logic                                         CLK,
  input  logic                                         RESETN,
  input  logic [DIN_WIDTH-1:0]                         din,
  input  logic                                         din_valid,
  output logic                                         ready,
  output logic [DOUT_WIDTH-1:0]                        dout,
  output logic                                         dout_valid,
  output logic [width_reduce_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);

  import width_reduce_pkg::*;

  localparam int LEVEL_WIDTH = ceil_log2(FIFO_DEPTH + 1);

  logic wr_en;
  logic full;
  logic almost_full;
  logic rd_en;
  logic not_empty;
  logic [DIN_WIDTH-1:0] rd_data;
  // occupancy, observed only by the bound checker
  logic [LEVEL_WIDTH-1:0] level;

  ingress_gate u_ingress_gate (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .din_valid   (din_valid),
    .full        (full),
    .almost_full (almost_full),
    .wr_en       (wr_en),
    .ready       (ready),
    .drop_count  (drop_count)
  );

  stream_fifo #(
    .WIDTH              (DIN_WIDTH),
    .DEPTH              (FIFO_DEPTH),
    .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
  ) u_stream_fifo (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .wr_en       (wr_en),
    .wr_data     (din),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .not_empty   (not_empty),
    .full        (full),
    .almost_full (almost_full),
    .level       (level)
  );

  width_reducer #(
    .DIN_WIDTH  (DIN_WIDTH),
    .DOUT_WIDTH (DOUT_WIDTH)
  ) u_width_reducer (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .rd_data    (rd_data),
    .not_empty  (not_empty),
    .rd_en      (rd_en),
    .dout       (dout),
    .dout_valid (dout_valid)
  );

endmodule

//--- design/width_reducer.sv
`timescale 1ns/100ps

module width_reducer #(
  parameter int DIN_WIDTH  = width_reduce_pkg::DEFAULT_DIN_WIDTH,
  parameter int DOUT_WIDTH = width_reduce_pkg::DEFAULT_DOUT_WIDTH
) (
  input  logic                  CLK,
  input  logic                  RESETN,
  input  logic [DIN_WIDTH-1:0]  rd_data,
  input  logic                  not_empty,
  output logic                  rd_en,
  output logic [DOUT_WIDTH-1:0] dout,
  output logic                  dout_valid
);

  import width_reduce_pkg::*;

  localparam int LANES = DIN_WIDTH / DOUT_WIDTH;
  localparam int CNT_WIDTH = ceil_log2(LANES);
  localparam logic [CNT_WIDTH-1:0] LAST_LANE = CNT_WIDTH'(LANES - 1);

  // only whole ratios are supported
  generate
    if ((DIN_WIDTH % DOUT_WIDTH) != 0) begin : g_bad_ratio
      $error("width_reducer: DIN_WIDTH must be a multiple of DOUT_WIDTH");
    end
  endgenerate

  logic [DIN_WIDTH-1:0] hold;
  logic [CNT_WIDTH-1:0] lane_cnt;
  logic busy;
  logic last_lane;
  logic [DOUT_WIDTH-1:0] lane_data [LANES];

  // slice the held word, lane 0 is the least significant
  genvar i;
  generate
    for (i = 0; i < LANES; i++) begin : g_lane
      assign lane_data[i] = hold[i*DOUT_WIDTH +: DOUT_WIDTH];
    end
  endgenerate

  assign last_lane = (lane_cnt == LAST_LANE);

  // pop when idle or on the final lane so words run back to back
  assign rd_en = not_empty && (!busy || last_lane);

  // holding register, loaded at each pop
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      hold <= rd_data;
    end
  end

  // lane sequencing
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      busy <= 1'b0;
      lane_cnt <= '0;
    end else if (rd_en) begin
      busy <= 1'b1;
      lane_cnt <= '0;
    end else if (busy) begin
      if (last_lane) begin
        busy <= 1'b0;
        lane_cnt <= '0;
      end else begin
        lane_cnt <= lane_cnt + 1'b1;
      end
    end
  end

  // output register keeps its last lane while idle
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      dout_valid <= 1'b0;
      dout <= '1;
    end else begin
      dout_valid <= busy;
      if (busy) begin
        dout <= lane_data[lane_cnt];
      end
    end
  end

endmodule

//--- design/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
  parameter int WIDTH              = width_reduce_pkg::DEFAULT_DIN_WIDTH,
  parameter int DEPTH              = width_reduce_pkg::DEFAULT_FIFO_DEPTH,
  parameter int ALMOST_FULL_MARGIN = width_reduce_pkg::DEFAULT_ALMOST_FULL_MARGIN
) (
  input  logic                                              CLK,
  input  logic                                              RESETN,
  input  logic                                              wr_en,
  input  logic [WIDTH-1:0]                                  wr_data,
  input  logic                                              rd_en,
  output logic [WIDTH-1:0]                                  rd_data,
  output logic                                              not_empty,
  output logic                                              full,
  output logic                                              almost_full,
  output logic [width_reduce_pkg::ceil_log2(DEPTH+1)-1:0]   level
);

  import width_reduce_pkg::*;

  localparam int PTR_WIDTH = ceil_log2(DEPTH);
  localparam int LEVEL_WIDTH = ceil_log2(DEPTH + 1);
  localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(DEPTH - 1);
  localparam logic [LEVEL_WIDTH-1:0] FULL_LEVEL = LEVEL_WIDTH'(DEPTH);
  localparam logic [LEVEL_WIDTH-1:0] AF_LEVEL = LEVEL_WIDTH'(DEPTH - ALMOST_FULL_MARGIN);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [LEVEL_WIDTH-1:0] count;
  logic do_write;
  logic do_read;

  // guard both ends so a stray strobe cannot corrupt the pointers
  assign do_write = wr_en && !full;
  assign do_read = rd_en && not_empty;

  // storage array
  always_ff @(posedge CLK) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap explicitly so any depth works
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
    end else if (do_write) begin
      wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      rd_ptr <= '0;
    end else if (do_read) begin
      rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
    end
  end

  // occupancy, unchanged on simultaneous write and read
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      count <= '0;
    end else begin
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry shown directly
  assign rd_data = mem[rd_ptr];

  assign not_empty = (count != '0);
  assign full = (count == FULL_LEVEL);
  assign almost_full = (count >= AF_LEVEL);
  assign level = count;

endmodule

//--- design/ingress_gate.sv
`timescale 1ns/100ps

module ingress_gate (
  input  logic                                         CLK,
  input  logic                                         RESETN,
  input  logic                                         din_valid,
  input  logic                                         full,
  input  logic                                         almost_full,
  output logic                                         wr_en,
  output logic                                         ready,
  output logic [width_reduce_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);

  import width_reduce_pkg::*;

  localparam logic [DROP_COUNT_WIDTH-1:0] DROP_MAX = '1;

  logic dropped;
  logic at_max;

  // full alone decides admission, even when the reader pops this cycle
  assign wr_en = din_valid && !full;

  // word offered into a full buffer is lost
  assign dropped = din_valid && full;

  assign at_max = (drop_count == DROP_MAX);

  // saturating count of lost words
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      drop_count <= '0;
    end else if (dropped && !at_max) begin
      drop_count <= drop_count + 1'b1;
    end
  end

  // advisory level for the source, one cycle behind the flags
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      ready <= 1'b0;
    end else begin
      ready <= !(full || almost_full);
    end
  end

endmodule

//--- design/width_reduce_pkg.sv
package width_reduce_pkg;

  // stream widths in bits
  localparam int DEFAULT_DIN_WIDTH = 128;
  localparam int DEFAULT_DOUT_WIDTH = 32;

  // buffer sizing in words
  localparam int DEFAULT_FIFO_DEPTH = 8;
  localparam int DEFAULT_ALMOST_FULL_MARGIN = 2;

  // saturating drop counter
  localparam int DROP_COUNT_WIDTH = 16;

  // bits needed to index a count of value items, never less than one
  function automatic int ceil_log2(input int value);
    int bits;
    int rem;
    bits = 0;
    rem = value - 1;
    while (rem > 0) begin
      bits = bits + 1;
      rem = rem >> 1;
    end
    if (bits == 0) begin
      bits = 1;
    end
    return bits;
  endfunction

endpackage
